/* include/rv_exec_consts.svh */
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// Datapath width
// Also the width of PC and branch targets
`define XLEN 32

// Register index width for x0 to x31
`define REG_AW 5

// Link increment for JAL and JALR
// One 32-bit instruction word
`define PC_STEP 4

`endif

/* src/rv_exec_pkg.sv */
package rv_exec_pkg;

    // Operation class delivered by decode
    // Selects the ALU operands and the redirect behavior
    typedef enum logic [2:0] {
        OPC_MEM    = 3'b000, // Load or store address
        OPC_BRANCH = 3'b001, // Conditional branch
        OPC_REG    = 3'b010, // R-type or I-type arithmetic
        OPC_JAL    = 3'b011, // Jump and link
        OPC_LUI    = 3'b100, // Load upper immediate
        OPC_AUIPC  = 3'b101, // Add upper immediate to PC
        OPC_JALR   = 3'b111  // Jump and link register
    } op_class_e;

    // ALU operation
    // Low bits follow funct3 and bit 3 marks SUB and SRA
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010, // Signed less than
        ALU_SLTU = 4'b0011, // Unsigned less than
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101, // Sign-filling right shift
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    // Branch condition as coded in funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100, // Signed
        BR_GE  = 3'b101, // Signed
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

endpackage

/* src/ex_ctrl_if.sv */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

interface ex_ctrl_if;

    logic               mem_write;  // Store in MEM
    logic               mem_read;   // Load in MEM
    logic               reg_write;  // Writeback enable
    logic               mem_to_reg; // Writeback takes load data
    logic [`REG_AW-1:0] rd;         // Destination register

    // Producer of the bundle
    modport drive (
        output mem_write,
        output mem_read,
        output reg_write,
        output mem_to_reg,
        output rd
    );

    // Pipeline register input side
    modport stage (
        input mem_write,
        input mem_read,
        input reg_write,
        input mem_to_reg,
        input rd
    );

    // Read-only access to the registered bundle
    modport view (
        input mem_write,
        input mem_read,
        input reg_write,
        input mem_to_reg,
        input rd
    );

endinterface

/* src/operand_select.sv */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module operand_select (
    input  rv_exec_pkg::op_class_e op_class,  // Operation class from decode
    input  logic                   alu_src,   // 1 picks imm for OPC_REG
    input  logic [`XLEN-1:0]       rs1_value,
    input  logic [`XLEN-1:0]       rs2_value,
    input  logic [`XLEN-1:0]       imm,       // Already sign extended by decode
    input  logic [`XLEN-1:0]       pc,
    output logic [`XLEN-1:0]       op_a,
    output logic [`XLEN-1:0]       op_b
);

    import rv_exec_pkg::*;

    // Link step widened to the datapath
    localparam logic [`XLEN-1:0] LINK_STEP = `XLEN'(`PC_STEP);

    always_comb
    begin
        op_a = rs1_value; // Most classes start from rs1
        op_b = imm;
        case (op_class)
            OPC_MEM:
            begin
                op_a = rs1_value; // Effective address
                op_b = imm;
            end
            OPC_BRANCH:
            begin
                op_a = rs1_value; // Compare operands
                op_b = rs2_value;
            end
            OPC_REG:
            begin
                op_a = rs1_value;
                op_b = alu_src ? imm : rs2_value; // I-type or R-type
            end
            OPC_LUI:
            begin
                op_a = '0; // Result is the immediate itself
                op_b = imm;
            end
            OPC_AUIPC:
            begin
                op_a = pc;
                op_b = imm;
            end
            OPC_JAL, OPC_JALR:
            begin
                // ALU produces the link address
                op_a = pc;
                op_b = LINK_STEP;
            end
            default:
            begin
                op_a = rs1_value; // Unused class code
                op_b = imm;
            end
        endcase
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module alu (
    input  rv_exec_pkg::alu_op_e alu_op,
    input  logic [`XLEN-1:0]     op_a,
    input  logic [`XLEN-1:0]     op_b,
    output logic [`XLEN-1:0]     result,
    output logic                 zero    // Result is all zeros
);

    import rv_exec_pkg::*;

    logic [4:0] shamt;    // Shift amount
    logic       lt_s;     // Signed compare
    logic       lt_u;     // Unsigned compare

    // RV32I takes only the low five bits of B for shifts
    assign shamt = op_b[4:0];

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb
    begin
        case (alu_op)
            ALU_ADD:
            begin
                result = op_a + op_b;
            end
            ALU_SUB:
            begin
                result = op_a - op_b;
            end
            ALU_SLL:
            begin
                result = op_a << shamt;
            end
            ALU_SLT:
            begin
                result = {{(`XLEN-1){1'b0}}, lt_s}; // 0 or 1
            end
            ALU_SLTU:
            begin
                result = {{(`XLEN-1){1'b0}}, lt_u};
            end
            ALU_XOR:
            begin
                result = op_a ^ op_b;
            end
            ALU_SRL:
            begin
                result = op_a >> shamt; // Zero fill
            end
            ALU_SRA:
            begin
                result = $unsigned($signed(op_a) >>> shamt); // Sign fill
            end
            ALU_OR:
            begin
                result = op_a | op_b;
            end
            ALU_AND:
            begin
                result = op_a & op_b;
            end
            default:
            begin
                result = '0; // Unused opcode
            end
        endcase
    end

    // Only reaches the debug port in MEM
    assign zero = (result == '0);

endmodule

/* src/branch_resolve.sv */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module branch_resolve (
    input  rv_exec_pkg::op_class_e op_class,
    input  rv_exec_pkg::br_cond_e  br_cond,   // Ignored unless OPC_BRANCH
    input  logic [`XLEN-1:0]       rs1_value,
    input  logic [`XLEN-1:0]       rs2_value,
    input  logic [`XLEN-1:0]       imm,
    input  logic [`XLEN-1:0]       pc,
    output logic                   taken,     // Redirect the fetch stage
    output logic [`XLEN-1:0]       target
);

    import rv_exec_pkg::*;

    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic             cond_hit;   // Branch condition holds
    logic [`XLEN-1:0] pc_target;  // Branch and JAL
    logic [`XLEN-1:0] reg_target; // JALR

    // Own comparator so the ALU stays free for the operands it was given
    assign eq   = (rs1_value == rs2_value);
    assign lt_s = $signed(rs1_value) < $signed(rs2_value);
    assign lt_u = rs1_value < rs2_value;

    assign pc_target  = pc + imm;
    assign reg_target = (rs1_value + imm) & {{(`XLEN-1){1'b1}}, 1'b0}; // Clear bit 0

    always_comb
    begin
        case (br_cond)
            BR_EQ:   cond_hit = eq;
            BR_NE:   cond_hit = !eq;
            BR_LT:   cond_hit = lt_s;
            BR_GE:   cond_hit = !lt_s;
            BR_LTU:  cond_hit = lt_u;
            BR_GEU:  cond_hit = !lt_u;
            default: cond_hit = 1'b0; // Reserved funct3
        endcase
    end

    always_comb
    begin
        taken  = 1'b0;
        target = pc_target;
        case (op_class)
            OPC_BRANCH:
            begin
                taken = cond_hit;
            end
            OPC_JAL:
            begin
                taken = 1'b1; // Unconditional
            end
            OPC_JALR:
            begin
                taken  = 1'b1;
                target = reg_target;
            end
            default:
            begin
                taken = 1'b0;
            end
        endcase
    end

    // PC-relative targets keep the word alignment of the offset
    always_comb
    begin
        a_target_aligned: assert final (!(taken && op_class != OPC_JALR &&
                                          imm[1:0] == 2'b00)
                                        || target[1:0] == 2'b00)
            else $error("branch_resolve: misaligned target %h", target);
    end

endmodule

/* src/ex_mem_reg.sv */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module ex_mem_reg #(
    parameter int RES_W = `XLEN // Width of the result path
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,       // 0 means bubble
    input  logic [RES_W-1:0] result,
    input  logic [`XLEN-1:0] store_data,
    input  logic             taken,
    input  logic [`XLEN-1:0] target,
    ex_ctrl_if.stage         ctrl_in,
    output logic             out_valid,
    output logic [RES_W-1:0] out_result,
    output logic [`XLEN-1:0] out_store_data,
    output logic             out_redirect,
    output logic [`XLEN-1:0] out_target,
    ex_ctrl_if.drive         ctrl_out
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_valid           <= 1'b0;
            out_redirect        <= 1'b0;
            out_result          <= '0;
            out_store_data      <= '0;
            out_target          <= '0;
            ctrl_out.mem_write  <= 1'b0;
            ctrl_out.mem_read   <= 1'b0;
            ctrl_out.reg_write  <= 1'b0;
            ctrl_out.mem_to_reg <= 1'b0;
            ctrl_out.rd         <= '0;
        end
        else
        begin
            out_valid    <= in_valid;
            out_redirect <= in_valid & taken; // No redirect from a bubble
            // Side effects are masked for a bubble
            ctrl_out.mem_write  <= in_valid & ctrl_in.mem_write;
            ctrl_out.mem_read   <= in_valid & ctrl_in.mem_read;
            ctrl_out.reg_write  <= in_valid & ctrl_in.reg_write;
            ctrl_out.mem_to_reg <= in_valid & ctrl_in.mem_to_reg;
            ctrl_out.rd         <= ctrl_in.rd;
            // Payload moves every cycle
            out_result     <= result;
            out_store_data <= store_data;
            out_target     <= target;
        end
    end

    // MEM never sees a load and a store at once
    a_no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(ctrl_out.mem_read && ctrl_out.mem_write))
        else $error("ex_mem_reg: mem_read and mem_write both set");

    // Fetch only ever gets a halfword aligned target
    a_redirect_aligned: assert property (@(posedge clk) disable iff (rst)
        out_redirect |-> !out_target[0])
        else $error("ex_mem_reg: redirect to odd target %h", out_target);

endmodule

/* src/execute.sv */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module execute (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  rv_exec_pkg::op_class_e op_class,
    input  logic                   alu_src,        // Imm instead of rs2 for OPC_REG
    input  rv_exec_pkg::alu_op_e   alu_op,
    input  rv_exec_pkg::br_cond_e  br_cond,
    input  logic [`XLEN-1:0]       rs1_value,
    input  logic [`XLEN-1:0]       rs2_value,
    input  logic [`XLEN-1:0]       imm,
    input  logic [`XLEN-1:0]       pc,
    input  logic                   in_mem_write,
    input  logic                   in_mem_read,
    input  logic                   in_reg_write,
    input  logic                   in_mem_to_reg,
    input  logic [`REG_AW-1:0]     in_rd,
    output logic                   out_valid,
    output logic [`XLEN-1:0]       out_result,     // ALU result or address
    output logic                   out_zero,       // Debug only
    output logic [`XLEN-1:0]       out_store_data,
    output logic                   out_redirect,
    output logic [`XLEN-1:0]       out_target,
    output logic                   out_mem_write,
    output logic                   out_mem_read,
    output logic                   out_reg_write,
    output logic                   out_mem_to_reg,
    output logic [`REG_AW-1:0]     out_rd
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic             alu_zero;
    logic             br_taken;
    logic [`XLEN-1:0] br_target;
    logic [`XLEN:0]   out_packed;  // Zero flag sits above the result

    ex_ctrl_if ctrl_in_if ();  // Bundle from decode
    ex_ctrl_if ctrl_out_if (); // Bundle toward MEM

    assign ctrl_in_if.mem_write  = in_mem_write;
    assign ctrl_in_if.mem_read   = in_mem_read;
    assign ctrl_in_if.reg_write  = in_reg_write;
    assign ctrl_in_if.mem_to_reg = in_mem_to_reg;
    assign ctrl_in_if.rd         = in_rd;

    operand_select u_operand_select (
        .op_class  (op_class),
        .alu_src   (alu_src),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (imm),
        .pc        (pc),
        .op_a      (op_a),
        .op_b      (op_b)
    );

    alu u_alu (
        .alu_op (alu_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    branch_resolve u_branch_resolve (
        .op_class  (op_class),
        .br_cond   (br_cond),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (imm),
        .pc        (pc),
        .taken     (br_taken),
        .target    (br_target)
    );

    // Zero flag rides along the result path
    ex_mem_reg #(
        .RES_W (`XLEN + 1)
    ) u_ex_mem_reg (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .result         ({alu_zero, alu_result}),
        .store_data     (rs2_value),   // Stores write rs2
        .taken          (br_taken),
        .target         (br_target),
        .ctrl_in        (ctrl_in_if),
        .out_valid      (out_valid),
        .out_result     (out_packed),
        .out_store_data (out_store_data),
        .out_redirect   (out_redirect),
        .out_target     (out_target),
        .ctrl_out       (ctrl_out_if)
    );

    assign out_zero   = out_packed[`XLEN];
    assign out_result = out_packed[`XLEN-1:0];

    assign out_mem_write  = ctrl_out_if.mem_write;
    assign out_mem_read   = ctrl_out_if.mem_read;
    assign out_reg_write  = ctrl_out_if.reg_write;
    assign out_mem_to_reg = ctrl_out_if.mem_to_reg;
    assign out_rd         = ctrl_out_if.rd;

endmodule

/* bench/execute_tb.sv */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module execute_tb;

    import rv_exec_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int PER_GROUP    = 16;  // Instructions per ALU op, class or condition
    localparam int MIX_CYCLES   = 200;
    // 10 ALU ops, 3 address classes, 6 conditions, 2 jumps, one drain cycle per test
    localparam int STIM_CYCLES  = 21 * PER_GROUP + MIX_CYCLES + 6;
    localparam int WATCHDOG_NS  = STIM_CYCLES * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;

    typedef struct packed {
        logic               valid;
        op_class_e          op_class;
        logic               alu_src;
        alu_op_e            alu_op;
        br_cond_e           br_cond;
        logic [`XLEN-1:0]   rs1;
        logic [`XLEN-1:0]   rs2;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   pc;
        logic               mem_write;
        logic               mem_read;
        logic               reg_write;
        logic               mem_to_reg;
        logic [`REG_AW-1:0] rd;
    } instr_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   result;
        logic               zero;
        logic [`XLEN-1:0]   store_data;
        logic               redirect;
        logic [`XLEN-1:0]   target;
        logic               mem_write;
        logic               mem_read;
        logic               reg_write;
        logic               mem_to_reg;
        logic [`REG_AW-1:0] rd;
    } expect_t;

    logic               clk;
    logic               rst;
    logic               in_valid;
    op_class_e          op_class;
    logic               alu_src;
    alu_op_e            alu_op;
    br_cond_e           br_cond;
    logic [`XLEN-1:0]   rs1_value;
    logic [`XLEN-1:0]   rs2_value;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   pc;
    logic               in_mem_write;
    logic               in_mem_read;
    logic               in_reg_write;
    logic               in_mem_to_reg;
    logic [`REG_AW-1:0] in_rd;
    logic               out_valid;
    logic [`XLEN-1:0]   out_result;
    logic               out_zero;
    logic [`XLEN-1:0]   out_store_data;
    logic               out_redirect;
    logic [`XLEN-1:0]   out_target;
    logic               out_mem_write;
    logic               out_mem_read;
    logic               out_reg_write;
    logic               out_mem_to_reg;
    logic [`REG_AW-1:0] out_rd;

    expect_t exp_q[$];     // One entry per driven cycle
    int      checks = 0;
    int      errors = 0;
    int      mark_checks = 0; // Counts at the start of the current test
    int      mark_errors = 0;

    execute DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a run that stops making progress
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // Signed compare from the sign bits, then magnitude
    function automatic logic lt_signed(logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
        return (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);
    endfunction

    function automatic logic [`XLEN-1:0] alu_ref(alu_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
        logic [4:0]       sh;
        logic [`XLEN-1:0] fill;
        sh   = b[4:0];                                          // Low five bits only
        fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;        // Sign bits for SRA
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 1;                        // Two's complement
            ALU_SLL:  return a << sh;
            ALU_SLT:  return `XLEN'(lt_signed(a, b));
            ALU_SLTU: return `XLEN'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | fill;
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic cond_ref(br_cond_e c, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
        case (c)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return lt_signed(a, b);
            BR_GE:   return !lt_signed(a, b);
            BR_LTU:  return a < b;
            default: return !(a < b);                           // BR_GEU
        endcase
    endfunction

    // Expected EX/MEM contents for one instruction
    function automatic expect_t predict(instr_t ins);
        expect_t          e;
        logic [`XLEN-1:0] jalr_sum;
        e        = '0;
        jalr_sum = ins.rs1 + ins.imm;
        case (ins.op_class)
            OPC_REG:    e.result = alu_ref(ins.alu_op, ins.rs1, ins.alu_src ? ins.imm : ins.rs2);
            OPC_MEM:    e.result = ins.rs1 + ins.imm;           // Effective address
            OPC_LUI:    e.result = ins.imm;
            OPC_AUIPC:  e.result = ins.pc + ins.imm;
            OPC_BRANCH:
            begin
                e.result   = alu_ref(ins.alu_op, ins.rs1, ins.rs2);
                e.redirect = cond_ref(ins.br_cond, ins.rs1, ins.rs2);
                e.target   = ins.pc + ins.imm;
            end
            OPC_JAL:
            begin
                e.result   = ins.pc + `PC_STEP;                 // Link address
                e.redirect = 1'b1;
                e.target   = ins.pc + ins.imm;
            end
            default:
            begin
                e.result   = ins.pc + `PC_STEP;                 // JALR
                e.redirect = 1'b1;
                e.target   = {jalr_sum[`XLEN-1:1], 1'b0};
            end
        endcase
        e.valid      = ins.valid;
        e.zero       = (e.result == '0);
        e.store_data = ins.rs2;
        e.redirect   = ins.valid & e.redirect;                  // Bubbles never redirect
        e.mem_write  = ins.valid & ins.mem_write;
        e.mem_read   = ins.valid & ins.mem_read;
        e.reg_write  = ins.valid & ins.reg_write;
        e.mem_to_reg = ins.valid & ins.mem_to_reg;
        e.rd         = ins.rd;
        return e;
    endfunction

    function automatic logic [`XLEN-1:0] sext(logic [`XLEN-1:0] raw, int bits);
        logic [`XLEN-1:0] s;
        s = raw << (`XLEN - bits);
        return `XLEN'($signed(s) >>> (`XLEN - bits));
    endfunction

    // Corner values mixed into the random operands
    function automatic logic [`XLEN-1:0] rand_word(logic [`XLEN-1:0] other);
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return `XLEN'($urandom_range(0, 31));
            2:       return 32'h8000_0000;
            3:       return 32'hFFFF_FFFF;
            4:       return 32'h7FFF_FFFF;
            5:       return other;                              // Equal operands
            default: return $urandom;
        endcase
    endfunction

    function automatic alu_op_e alu_by_index(int i);
        case (i)
            0:       return ALU_ADD;
            1:       return ALU_SUB;
            2:       return ALU_SLL;
            3:       return ALU_SLT;
            4:       return ALU_SLTU;
            5:       return ALU_XOR;
            6:       return ALU_SRL;
            7:       return ALU_SRA;
            8:       return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic br_cond_e cond_by_index(int i);
        case (i)
            0:       return BR_EQ;
            1:       return BR_NE;
            2:       return BR_LT;
            3:       return BR_GE;
            4:       return BR_LTU;
            default: return BR_GEU;
        endcase
    endfunction

    function automatic op_class_e class_by_index(int i);
        case (i)
            0:       return OPC_MEM;
            1:       return OPC_BRANCH;
            2:       return OPC_REG;
            3:       return OPC_JAL;
            4:       return OPC_LUI;
            5:       return OPC_AUIPC;
            default: return OPC_JALR;
        endcase
    endfunction

    // Random legal instruction of one class
    function automatic instr_t make_instr(op_class_e cls, alu_op_e op, br_cond_e cond,
                                          logic valid);
        instr_t ins;
        logic   is_store;
        ins          = '0;
        is_store     = 1'($urandom_range(0, 1));
        ins.valid    = valid;
        ins.op_class = cls;
        ins.alu_src  = 1'($urandom_range(0, 1));
        ins.alu_op   = ALU_ADD;                                 // Decode adds for addresses
        ins.br_cond  = cond;
        ins.rs1      = rand_word($urandom);
        ins.rs2      = rand_word(ins.rs1);
        ins.pc       = $urandom & ~32'h3;                       // Word aligned fetch
        ins.rd       = `REG_AW'($urandom_range(0, 31));
        ins.imm      = sext($urandom, 12);
        ins.reg_write = (cls != OPC_BRANCH) && !(cls == OPC_MEM && is_store);
        case (cls)
            OPC_REG:    ins.alu_op = op;
            OPC_BRANCH:
            begin
                ins.alu_op = ALU_SUB;
                ins.imm    = sext($urandom, 13) & ~32'h1;
            end
            OPC_MEM:
            begin
                ins.mem_write  = is_store;
                ins.mem_read   = !is_store;
                ins.mem_to_reg = !is_store;
            end
            OPC_LUI, OPC_AUIPC: ins.imm = $urandom & 32'hFFFF_F000;
            OPC_JAL:            ins.imm = sext($urandom, 21) & ~32'h1;
            default:            ;                               // JALR keeps the I immediate
        endcase
        return ins;
    endfunction

    task automatic check_val(string name, logic [`XLEN-1:0] expected, logic [`XLEN-1:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("CHECK FAILED time %0t: %s expected %h, got %h", $time, name, expected,
                     actual);
        end
    endtask

    task automatic compare(expect_t e);
        check_val("out_valid", `XLEN'(e.valid), `XLEN'(out_valid));
        check_val("out_redirect", `XLEN'(e.redirect), `XLEN'(out_redirect));
        check_val("out_mem_write", `XLEN'(e.mem_write), `XLEN'(out_mem_write));
        check_val("out_mem_read", `XLEN'(e.mem_read), `XLEN'(out_mem_read));
        check_val("out_reg_write", `XLEN'(e.reg_write), `XLEN'(out_reg_write));
        check_val("out_mem_to_reg", `XLEN'(e.mem_to_reg), `XLEN'(out_mem_to_reg));
        if (e.valid)
        begin
            check_val("out_result", e.result, out_result);
            check_val("out_zero", `XLEN'(e.zero), `XLEN'(out_zero));
            check_val("out_store_data", e.store_data, out_store_data);
            check_val("out_rd", `XLEN'(e.rd), `XLEN'(out_rd));
        end
        if (e.redirect)
            check_val("out_target", e.target, out_target);
    endtask

    // Drives one cycle and checks the instruction of the cycle before
    task automatic drive(instr_t ins);
        @(posedge clk);
        in_valid      <= ins.valid;
        op_class      <= ins.op_class;
        alu_src       <= ins.alu_src;
        alu_op        <= ins.alu_op;
        br_cond       <= ins.br_cond;
        rs1_value     <= ins.rs1;
        rs2_value     <= ins.rs2;
        imm           <= ins.imm;
        pc            <= ins.pc;
        in_mem_write  <= ins.mem_write;
        in_mem_read   <= ins.mem_read;
        in_reg_write  <= ins.reg_write;
        in_mem_to_reg <= ins.mem_to_reg;
        in_rd         <= ins.rd;
        exp_q.push_back(predict(ins));
        @(negedge clk);                                          // Outputs settled here
        if (exp_q.size() > 1)
            compare(exp_q.pop_front());
    endtask

    task automatic drain();
        drive(make_instr(OPC_MEM, ALU_ADD, BR_EQ, 1'b0));       // Bubble flushes the last one
    endtask

    task automatic report(string name);
        $display("%-24s %5d checks %4d errors", name, checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    initial
    begin
        void'($urandom(78));
        rst           = 1'b1;
        in_valid      = 1'b0;
        op_class      = OPC_MEM;
        alu_src       = 1'b0;
        alu_op        = ALU_ADD;
        br_cond       = BR_EQ;
        rs1_value     = '0;
        rs2_value     = '0;
        imm           = '0;
        pc            = '0;
        in_mem_write  = 1'b0;
        in_mem_read   = 1'b0;
        in_reg_write  = 1'b0;
        in_mem_to_reg = 1'b0;
        in_rd         = '0;

        // Reset values, then the first cycle out of reset
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        compare('0);
        check_val("out_result", '0, out_result);
        check_val("out_zero", '0, `XLEN'(out_zero));
        check_val("out_store_data", '0, out_store_data);
        check_val("out_target", '0, out_target);
        check_val("out_rd", '0, `XLEN'(out_rd));
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare('0);
        report("reset");

        for (int i = 0; i < 10; i++)
            repeat (PER_GROUP) drive(make_instr(OPC_REG, alu_by_index(i), BR_EQ, 1'b1));
        drain();
        report("register ops");

        repeat (PER_GROUP) drive(make_instr(OPC_MEM, ALU_ADD, BR_EQ, 1'b1));
        repeat (PER_GROUP) drive(make_instr(OPC_LUI, ALU_ADD, BR_EQ, 1'b1));
        repeat (PER_GROUP) drive(make_instr(OPC_AUIPC, ALU_ADD, BR_EQ, 1'b1));
        drain();
        report("address and upper imm");

        for (int i = 0; i < 6; i++)
            repeat (PER_GROUP) drive(make_instr(OPC_BRANCH, ALU_SUB, cond_by_index(i), 1'b1));
        drain();
        report("branches");

        repeat (PER_GROUP) drive(make_instr(OPC_JAL, ALU_ADD, BR_EQ, 1'b1));
        repeat (PER_GROUP) drive(make_instr(OPC_JALR, ALU_ADD, BR_EQ, 1'b1));
        drain();
        report("jumps");

        // Roughly 60 percent valid, so gaps and back-to-back runs both occur
        repeat (MIX_CYCLES)
            drive(make_instr(class_by_index($urandom_range(0, 6)),
                             alu_by_index($urandom_range(0, 9)),
                             cond_by_index($urandom_range(0, 5)),
                             1'($urandom_range(0, 9) < 6)));
        drain();
        report("bubbles and mix");

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* execute.f */
+incdir+include
src/rv_exec_pkg.sv
src/ex_ctrl_if.sv
src/operand_select.sv
src/alu.sv
src/branch_resolve.sv
src/ex_mem_reg.sv
src/execute.sv
bench/execute_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execute_tb
FILELIST  ?= execute.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= STATUS: PASS
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, not the exit code of the binary
run: $(BIN)
	@$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
